//--- eeprom_testdata.txt
// one hex word per operation: kind_addr_data_nack
// kind 0 write, 1 read (data is the expected byte), 2 write with a second wr while busy, f end
1_012_13_0
0_000_5a_0
1_000_5a_0
0_3ff_c3_0
1_3ff_c3_0
1_3fe_02_0
0_155_a7_0
1_155_a7_0
1_154_56_0
0_2c0_11_0
1_2c0_11_0
1_2c1_c4_0
0_450_77_1
1_7ff_00_1
2_0a0_3c_0
1_0a0_3c_0
1_000_5a_0
f_000_00_0

//--- flist.f
eeprom_pkg.sv
eeprom_bit_engine.sv
eeprom_sequencer.sv
eeprom_ctrl_top.sv
eeprom_properties.sv
tb_clock_gen.sv
eeprom_model.sv
eeprom_checker.sv
eeprom_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module eeprom_tb -f flist.f -o Veeprom_tb

./obj_dir/Veeprom_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0

//--- eeprom_tb.sv
`timescale 1ns/1ns
module eeprom_tb;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic        done;
    logic        nack;
    logic        busy;
    logic        scl;
    logic        sda_out;
    logic        sda_oe;
    logic        sda_master;
    logic        sda_in;
    logic        model_pull;
    logic        exp_read;
    logic [7:0]  exp_rdata;
    logic        exp_nack;
    logic        end_check;
    int          op_count;
    int          chk_errors;
    int          done_count;
    int          timeouts;
    logic [27:0] vectors [0:31]; // kind, addr, data, nack

    assign sda_master = sda_oe ? sda_out : 1'b1;
    assign sda_in     = sda_master && !model_pull; // pull-up on the bus

    tb_clock_gen u_tb_clock_gen (.CLK(CLK), .RESET(RESET));

    eeprom_ctrl_top #(.HALF_PERIOD(2)) u_eeprom_ctrl_top (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .sda_in(sda_in), .rdata(rdata), .done(done), .nack(nack), .busy(busy),
        .scl(scl), .sda_out(sda_out), .sda_oe(sda_oe)
    );

    eeprom_model u_eeprom_model (.CLK(CLK), .scl(scl), .sda(sda_master), .sda_pull(model_pull));

    eeprom_checker u_eeprom_checker (
        .CLK(CLK), .RESET(RESET), .done(done), .rdata(rdata), .nack(nack),
        .exp_read(exp_read), .exp_rdata(exp_rdata), .exp_nack(exp_nack),
        .op_count(op_count), .end_check(end_check), .errors(chk_errors),
        .done_count(done_count)
    );

    bind eeprom_ctrl_top eeprom_properties u_eeprom_properties (
        .CLK(CLK), .RESET(RESET), .state(u_eeprom_sequencer.state),
        .engine_busy(u_eeprom_bit_engine.active), .cmd_go(cmd_go), .done(done),
        .busy(busy), .sda_oe(sda_oe)
    );

    task automatic wait_reset_release();
        int n;
        n = 0;
        @(posedge CLK);
        while (RESET && n < 100)
        begin
            @(posedge CLK);
            n++;
        end
        if (RESET)
        begin
            $display("reset never released");
            timeouts++;
        end
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy && n < 2000)
        begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (busy)
        begin
            $display("controller stayed busy");
            timeouts++;
        end
    endtask

    task automatic wait_for_done(input int idx);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 2000)
        begin
            @(posedge CLK);
            #1;
            seen = done;
            n++;
        end
        if (!seen)
        begin
            $display("no done pulse for operation %0d", idx);
            timeouts++;
        end
    endtask

    initial
    begin
        logic [3:0] kind;
        int         i;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wdata     = '0;
        exp_read  = 1'b0;
        exp_rdata = '0;
        exp_nack  = 1'b0;
        end_check = 1'b0;
        op_count  = 0;
        timeouts  = 0;
        $readmemh("eeprom_testdata.txt", vectors);
        wait_reset_release();
        i    = 0;
        kind = vectors[0][27:24];
        while (kind != 4'hf && i < 32)
        begin
            wait_not_busy();
            exp_read  = (kind == 4'h1);
            exp_rdata = vectors[i][11:4];
            exp_nack  = vectors[i][0];
            op_count++;
            @(posedge CLK);
            #1;
            addr  = vectors[i][22:12];
            wdata = vectors[i][11:4];
            wr    = (kind != 4'h1);
            rd    = (kind == 4'h1);
            @(posedge CLK);
            #1;
            wr = 1'b0;
            rd = 1'b0;
            if (kind == 4'h2)
            begin
                repeat (2) @(posedge CLK); // second write lands mid transfer
                #1;
                wr    = 1'b1;
                wdata = ~vectors[i][11:4];
                @(posedge CLK);
                #1;
                wr = 1'b0;
            end
            wait_for_done(i);
            i++;
            if (i < 32)
                kind = vectors[i][27:24];
        end
        repeat (2) @(posedge CLK);
        #1 end_check = 1'b1;
        @(posedge CLK);
        #1 end_check = 1'b0;
        @(posedge CLK);
        #1;
        $display("errors: %0d compare, %0d timeout, %0d operations",
                 chk_errors, timeouts, op_count);
        if (chk_errors == 0 && timeouts == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- eeprom_checker.sv
`timescale 1ns/1ns
module eeprom_checker
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       done,
    input  logic [7:0] rdata,
    input  logic       nack,
    input  logic       exp_read,
    input  logic [7:0] exp_rdata,
    input  logic       exp_nack,
    input  int         op_count,
    input  logic       end_check,
    output int         errors,
    output int         done_count
);

    initial
    begin
        errors     = 0;
        done_count = 0;
    end

    always @(posedge CLK)
    begin
        int e;
        e = 0;
        if (!RESET && done)
        begin
            done_count <= done_count + 1;
            if (nack !== exp_nack)
            begin
                $display("error %0t ns nack expected %0b actual %0b", $time, exp_nack, nack);
                e++;
            end
            if (exp_read && !exp_nack && rdata !== exp_rdata)
            begin
                $display("error %0t ns rdata expected %02h actual %02h",
                         $time, exp_rdata, rdata);
                e++;
            end
        end
        if (end_check && done_count != op_count)
        begin
            $display("saw %0d done pulses for %0d operations", done_count, op_count);
            e++;
        end
        errors <= errors + e;
    end

endmodule

//--- eeprom_model.sv
`timescale 1ns/1ns
module eeprom_model import eeprom_pkg::*;
(
    input  logic CLK,
    input  logic scl,
    input  logic sda,      // master side of the line
    output logic sda_pull  // high pulls the bus low
);

    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_RDATA} mode_t;

    logic [7:0] mem [0:1023];
    mode_t      mode = M_IDLE;
    logic       scl_q = 1'b1;
    logic       sda_q = 1'b1;
    int         bitcnt = 0;
    logic [7:0] sh = 8'h00;
    logic       sending = 1'b0;
    logic       mack = 1'b1;
    logic [9:0] ptr = 10'd0;
    logic [1:0] blk = 2'd0;

    initial
    begin
        for (int i = 0; i < 1024; i++)
            mem[i] = i[7:0] + {6'd0, i[9:8]} + 8'd1; // fill depends on block too
        sda_pull = 1'b0;
    end

    // bus sampled on the system clock, edges seen one cycle late
    always @(posedge CLK)
    begin
        int         n;
        logic [9:0] nptr;
        n     = bitcnt + 1;
        nptr  = ptr + 10'd1;
        scl_q <= scl;
        sda_q <= sda;
        if (scl_q && scl && sda_q && !sda)
        begin
            mode     <= M_CTRL; // start or repeated start
            bitcnt   <= -1;
            sending  <= 1'b0;
            sda_pull <= 1'b0;
        end
        else if (scl_q && scl && !sda_q && sda)
        begin
            mode     <= M_IDLE; // stop
            sending  <= 1'b0;
            sda_pull <= 1'b0;
        end
        else if (!scl_q && scl)
        begin
            if (mode != M_IDLE && bitcnt >= 0 && bitcnt < 8 && !sending)
                sh <= {sh[6:0], sda};
            if (bitcnt == 8 && sending)
                mack <= sda;
        end
        else if (scl_q && !scl && mode != M_IDLE)
        begin
            bitcnt <= n;
            if (n == 8)
            begin
                sda_pull <= 1'b0;
                if (!sending)
                    case (mode)
                        M_CTRL:
                            if (sh[7:4] == DEVICE_TYPE && sh[3:1] < 3'd4)
                            begin
                                blk      <= sh[2:1];
                                sda_pull <= 1'b1;
                                mode     <= sh[0] ? M_RDATA : M_ADDR;
                            end
                            else
                                mode <= M_IDLE; // no such block
                        M_ADDR:
                        begin
                            ptr      <= {blk, sh};
                            sda_pull <= 1'b1;
                            mode     <= M_WDATA;
                        end
                        M_WDATA:
                        begin
                            mem[ptr] <= sh;
                            ptr      <= nptr;
                            sda_pull <= 1'b1;
                        end
                        default: sda_pull <= 1'b0;
                    endcase
            end
            else if (n == 9)
            begin
                bitcnt <= 0;
                if (sending)
                begin
                    if (mack)
                    begin
                        mode     <= M_IDLE; // master done reading
                        sending  <= 1'b0;
                        sda_pull <= 1'b0;
                    end
                    else
                    begin
                        ptr      <= nptr;
                        sh       <= mem[nptr];
                        sda_pull <= !mem[nptr][7];
                    end
                end
                else if (mode == M_RDATA)
                begin
                    sending  <= 1'b1;
                    sh       <= mem[ptr];
                    sda_pull <= !mem[ptr][7];
                end
                else
                    sda_pull <= 1'b0;
            end
            else if (sending && n > 0)
                sda_pull <= !sh[7-n];
        end
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns
module tb_clock_gen
(
    output logic CLK,
    output logic RESET
);

    initial
    begin
        CLK   = 1'b0;
        RESET = 1'b1;
        repeat (5) @(posedge CLK);
        #1 RESET = 1'b0;
    end

    always #50 CLK = ~CLK; // 100 ns period

endmodule

//--- eeprom_properties.sv
`timescale 1ns/1ns
module eeprom_properties import eeprom_pkg::*;
(
    input logic        CLK,
    input logic        RESET,
    input xfer_state_t state,
    input logic        engine_busy, // bit engine running a command
    input logic        cmd_go,
    input logic        done,
    input logic        busy,
    input logic        sda_oe
);

    a_done_single: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
        else $error("done longer than one cycle");

    a_reset_release: assert property (@(posedge CLK) RESET && $past(RESET) |-> !sda_oe)
        else $error("sda driven during reset");

    a_one_cmd: assert property (@(posedge CLK) disable iff (RESET) cmd_go |-> !engine_busy)
        else $error("command issued while one is in flight");

    a_idle_busy: assert property (@(posedge CLK) disable iff (RESET) state == ST_IDLE |-> !busy)
        else $error("busy high in idle");

endmodule

//--- eeprom_ctrl_top.sv
`timescale 1ns/1ns
module eeprom_ctrl_top import eeprom_pkg::*;
#(
    parameter int HALF_PERIOD = 2
)
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    input  logic        sda_in,
    output logic [7:0]  rdata,
    output logic        done,
    output logic        nack,
    output logic        busy,
    output logic        scl,
    output logic        sda_out,
    output logic        sda_oe
);

    logic       cmd_go;
    bit_cmd_t   cmd;
    logic [7:0] tx_byte;
    logic       master_ack;
    logic       cmd_done;
    logic [7:0] rx_byte;
    logic       slave_nack;

    eeprom_sequencer u_eeprom_sequencer (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .cmd_done   (cmd_done),
        .rx_byte    (rx_byte),
        .slave_nack (slave_nack),
        .cmd_go     (cmd_go),
        .cmd        (cmd),
        .tx_byte    (tx_byte),
        .master_ack (master_ack),
        .rdata      (rdata),
        .done       (done),
        .nack       (nack),
        .busy       (busy)
    );

    eeprom_bit_engine #(
        .HALF_PERIOD (HALF_PERIOD)
    ) u_eeprom_bit_engine (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_go     (cmd_go),
        .cmd        (cmd),
        .tx_byte    (tx_byte),
        .master_ack (master_ack),
        .sda_in     (sda_in),
        .cmd_done   (cmd_done),
        .rx_byte    (rx_byte),
        .slave_nack (slave_nack),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe)
    );

endmodule

//--- eeprom_sequencer.sv
`timescale 1ns/1ns
module eeprom_sequencer import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    input  logic        cmd_done,
    input  logic [7:0]  rx_byte,
    input  logic        slave_nack,
    output logic        cmd_go,
    output bit_cmd_t    cmd,
    output logic [7:0]  tx_byte,
    output logic        master_ack,
    output logic [7:0]  rdata,
    output logic        done,
    output logic        nack,
    output logic        busy
);

    xfer_state_t state;
    logic        wait_done; // command in flight
    logic        is_read;
    logic        accept;
    logic [10:0] addr_r;
    logic [7:0]  wdata_r;

    assign accept = (state == ST_IDLE) && (wr || rd);

    // one command per bus state, issued on entry
    assign cmd_go = (state != ST_IDLE) && (state != ST_DONE) && !wait_done;

    // random read is a single byte, so the master never acks it
    assign master_ack = 1'b0;

    always_comb
    begin
        case (state)
            ST_START, ST_RESTART: cmd = CMD_START;
            ST_STOP:              cmd = CMD_STOP;
            ST_DATA_RD:           cmd = CMD_READ;
            default:              cmd = CMD_WRITE;
        endcase
        case (state)
            ST_CTRL_WR: tx_byte = {DEVICE_TYPE, addr_r[10:8], 1'b0};
            ST_ADDR:    tx_byte = addr_r[7:0];
            ST_CTRL_RD: tx_byte = {DEVICE_TYPE, addr_r[10:8], 1'b1};
            default:    tx_byte = wdata_r;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= ST_IDLE;
            wait_done <= 1'b0;
            is_read   <= 1'b0;
            done      <= 1'b0;
            busy      <= 1'b0;
            nack      <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (cmd_go)
                wait_done <= 1'b1;
            else if (cmd_done)
                wait_done <= 1'b0;
            case (state)
                ST_IDLE:
                    if (accept)
                    begin
                        is_read <= !wr; // write wins
                        nack    <= 1'b0;
                        busy    <= 1'b1;
                        state   <= ST_START;
                    end
                ST_START:
                    if (cmd_done)
                        state <= ST_CTRL_WR;
                ST_CTRL_WR, ST_ADDR, ST_CTRL_RD:
                    if (cmd_done)
                    begin
                        if (slave_nack)
                        begin
                            nack  <= 1'b1;
                            state <= ST_STOP;
                        end
                        else if (state == ST_CTRL_WR)
                            state <= ST_ADDR;
                        else if (state == ST_CTRL_RD)
                            state <= ST_DATA_RD;
                        else
                            state <= is_read ? ST_RESTART : ST_DATA_WR;
                    end
                ST_DATA_WR:
                    if (cmd_done)
                    begin
                        nack  <= slave_nack;
                        state <= ST_STOP;
                    end
                ST_RESTART:
                    if (cmd_done)
                        state <= ST_CTRL_RD;
                ST_DATA_RD:
                    if (cmd_done)
                        state <= ST_STOP;
                ST_STOP:
                    if (cmd_done)
                    begin
                        done  <= 1'b1;
                        state <= ST_DONE;
                    end
                ST_DONE:
                begin
                    busy  <= 1'b0;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_r  <= addr;
            wdata_r <= wdata;
        end
        if (state == ST_DATA_RD && cmd_done)
            rdata <= rx_byte;
    end

endmodule

//--- eeprom_bit_engine.sv
`timescale 1ns/1ns
module eeprom_bit_engine import eeprom_pkg::*;
#(
    parameter int HALF_PERIOD = 2 // CLK cycles per SCL half, at least 2
)
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cmd_go,
    input  bit_cmd_t   cmd,
    input  logic [7:0] tx_byte,
    input  logic       master_ack,
    input  logic       sda_in,
    output logic       cmd_done,
    output logic [7:0] rx_byte,
    output logic       slave_nack,
    output logic       scl,
    output logic       sda_out,
    output logic       sda_oe
);

    localparam int CNT_W = $clog2(HALF_PERIOD + 1);

    logic             active;
    bit_cmd_t         cmd_r;
    logic [4:0]       phase;      // one step per SCL half period
    logic [4:0]       phase_nxt;
    logic [CNT_W-1:0] hp_cnt;
    logic             tick;
    logic             last_phase;
    logic             upd;        // sda update, one cycle behind scl
    logic             scl_nxt;
    logic             oe_nxt;
    logic [2:0]       bit_pos;
    logic [7:0]       tx_r;
    logic             ack_r;

    assign sda_out = 1'b0; // open drain, only ever pulls low

    assign tick       = active && (hp_cnt == CNT_W'(HALF_PERIOD - 1));
    assign last_phase = (cmd_r == CMD_START || cmd_r == CMD_STOP) ? (phase == 5'd1)
                                                                   : (phase == 5'd17);
    assign phase_nxt  = cmd_go ? 5'd0 : phase + 5'd1;

    // start keeps scl high; everything else low on even, high on odd phases
    assign scl_nxt = ((cmd_go ? cmd : cmd_r) == CMD_START) ? 1'b1 : phase_nxt[0];

    always_comb
    begin
        bit_pos = 3'd7 - phase[3:1]; // msb first
        case (cmd_r)
            CMD_START: oe_nxt = phase[0];   // pull sda low while scl high
            CMD_STOP:  oe_nxt = 1'b1;       // hold low, released on completion
            CMD_WRITE: oe_nxt = phase[4] ? 1'b0 : ~tx_r[bit_pos];
            default:   oe_nxt = phase[4] ? ack_r : 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active     <= 1'b0;
            cmd_r      <= CMD_STOP;
            phase      <= 5'd0;
            hp_cnt     <= '0;
            upd        <= 1'b0;
            cmd_done   <= 1'b0;
            slave_nack <= 1'b0;
            scl        <= 1'b1;
            sda_oe     <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            upd      <= cmd_go || (tick && !last_phase);
            if (upd)
                sda_oe <= oe_nxt;
            if (cmd_go)
            begin
                active <= 1'b1;
                cmd_r  <= cmd;
                phase  <= phase_nxt;
                hp_cnt <= '0;
                scl    <= scl_nxt;
            end
            else if (active)
            begin
                if (!tick)
                    hp_cnt <= hp_cnt + 1'b1;
                else
                begin
                    hp_cnt <= '0;
                    if (cmd_r == CMD_WRITE && phase == 5'd17)
                        slave_nack <= sda_in; // ack bit, high = no ack
                    if (last_phase)
                    begin
                        active   <= 1'b0;
                        cmd_done <= 1'b1;
                        scl      <= (cmd_r == CMD_STOP); // low after start and bytes
                        if (cmd_r == CMD_STOP)
                            sda_oe <= 1'b0; // stop edge
                    end
                    else
                    begin
                        phase <= phase_nxt;
                        scl   <= scl_nxt;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_go)
        begin
            tx_r  <= tx_byte;
            ack_r <= master_ack;
        end
        // sample at the end of each scl high half
        if (tick && cmd_r == CMD_READ && phase[0] && !phase[4])
            rx_byte <= {rx_byte[6:0], sda_in};
    end

endmodule

//--- eeprom_pkg.sv
package eeprom_pkg;

    // main transfer FSM states
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL_WR,
        ST_ADDR,
        ST_DATA_WR,
        ST_RESTART,
        ST_CTRL_RD,
        ST_DATA_RD,
        ST_STOP,
        ST_DONE
    } xfer_state_t;

    // commands handed to the bit engine
    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bit_cmd_t;

    localparam logic [3:0] DEVICE_TYPE = 4'b1010; // 24Cxx type code

endpackage
